//--- source/eeprom_pkg.sv
package eeprom_pkg;

  localparam int ADDR_W = 11;
  localparam int DATA_W = 8;
  localparam logic [3:0] DEV_CODE = 4'b1010;

  // clk cycles per quarter of an scl period
  localparam int QUARTER_CLKS = 2;
  localparam int QCNT_W = (QUARTER_CLKS > 1) ? $clog2(QUARTER_CLKS) : 1;

  typedef struct packed {
    logic              is_read;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
  } eeprom_cmd_t;

  typedef struct packed {
    logic [DATA_W-1:0] rdata;
    logic              err;
  } eeprom_result_t;

  // one-cycle pulses from the scl timer
  typedef struct packed {
    logic rise;
    logic fall;
    logic drive;   // mid scl low
    logic sample;  // mid scl high
  } scl_tick_t;

  typedef enum logic [1:0] {
    SH_IDLE,
    SH_SEND,
    SH_RECV
  } shift_op_e;

  // one-hot with bit 1 left spare
  typedef enum logic [10:0] {
    IDLE        = 11'b000_0000_0001,
    WRITE_START = 11'b000_0000_0100,
    CTRL_WRITE  = 11'b000_0000_1000,
    ADDR_WRITE  = 11'b000_0001_0000,
    DATA_WRITE  = 11'b000_0010_0000,
    READ_START  = 11'b000_0100_0000,
    CTRL_READ   = 11'b000_1000_0000,
    DATA_READ   = 11'b001_0000_0000,
    STOP        = 11'b010_0000_0000,
    ACKN        = 11'b100_0000_0000
  } main_state_e;

endpackage

//--- source/eeprom_cmd_regs.sv
`timescale 1ns/1ns
module eeprom_cmd_regs (
  input  logic                             clk,
  input  logic                             rst_n,
  input  logic                             wr,
  input  logic                             rd,
  input  logic [eeprom_pkg::ADDR_W-1:0]    addr,
  input  logic [eeprom_pkg::DATA_W-1:0]    wdata,
  input  logic                             done,
  input  eeprom_pkg::eeprom_result_t       result,
  output eeprom_pkg::eeprom_cmd_t          cmd,
  output logic                             start_req,
  output logic                             busy,
  output logic                             ack,
  output logic [eeprom_pkg::DATA_W-1:0]    rdata,
  output logic                             err
);
  import eeprom_pkg::*;

  logic accept;

  assign accept = (wr || rd) && !busy;  // strobes while busy are dropped

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      start_req <= 1'b0;
      busy      <= 1'b0;
      ack       <= 1'b0;
      err       <= 1'b0;
    end else begin
      start_req <= accept;
      ack       <= done;  // one clk after the engine finishes
      if (accept) begin
        busy <= 1'b1;
      end else if (done) begin
        busy <= 1'b0;
      end
      if (done) begin
        err <= result.err;
      end
    end
  end

  // command and read data
  always_ff @(posedge clk) begin
    if (accept) begin
      cmd.is_read <= rd;
      cmd.addr    <= addr;
      cmd.wdata   <= wdata;
    end
    if (done) begin
      rdata <= result.rdata;  // held until the next completion
    end
  end

  a_one_strobe: assert property (@(posedge clk) disable iff (!rst_n)
    !(wr && rd))
    else $error("wr and rd asserted together");

endmodule

//--- source/eeprom_scl_timer.sv
`timescale 1ns/1ns
module eeprom_scl_timer (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  run,
  output eeprom_pkg::scl_tick_t tick,
  output logic                  scl
);
  import eeprom_pkg::*;

  logic [QCNT_W-1:0] qcnt;
  logic [1:0]        phase;  // 0,1 scl low; 2,3 scl high
  logic              wrap;

  assign wrap = (qcnt == QCNT_W'(QUARTER_CLKS - 1));
  assign scl  = phase[1];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      qcnt  <= '0;
      phase <= 2'd2;
      tick  <= '0;
    end else begin
      tick <= '0;
      if (!run) begin
        // park just after a rise so the first tick is a sample
        qcnt  <= '0;
        phase <= 2'd2;
      end else if (wrap) begin
        qcnt  <= '0;
        phase <= phase + 2'd1;
        case (phase)
          2'd0:    tick.drive  <= 1'b1;
          2'd1:    tick.rise   <= 1'b1;
          2'd2:    tick.sample <= 1'b1;
          default: tick.fall   <= 1'b1;
        endcase
      end else begin
        qcnt <= qcnt + 1'b1;
      end
    end
  end

  a_stop_high: assert property (@(posedge clk) disable iff (!rst_n)
    $fell(run) |-> scl && $past(tick.sample))
    else $error("run dropped away from a sample tick");

endmodule

//--- source/eeprom_byte_shifter.sv
`timescale 1ns/1ns
module eeprom_byte_shifter (
  input  logic                          clk,
  input  logic                          rst_n,
  input  eeprom_pkg::scl_tick_t         tick,
  input  eeprom_pkg::shift_op_e         op,
  input  logic [eeprom_pkg::DATA_W-1:0] tx_byte,
  input  logic                          host_ack_bit,
  input  logic                          sda_in,
  output logic                          bit_out,
  output logic                          byte_done,
  output logic [eeprom_pkg::DATA_W-1:0] rx_byte,
  output logic                          ack_seen
);
  import eeprom_pkg::*;

  logic [DATA_W-1:0] sreg;
  logic [3:0]        slot;    // 0..7 data bits, 8 acknowledge
  logic              active;
  logic              ack_slot;

  assign ack_slot  = (slot == 4'd8);
  assign byte_done = active && ack_slot && tick.fall;
  assign rx_byte   = sreg;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      active   <= 1'b0;
      slot     <= '0;
      bit_out  <= 1'b1;  // released
      ack_seen <= 1'b0;
    end else begin
      if (tick.drive) begin
        if (!active && op != SH_IDLE) begin
          active  <= 1'b1;
          slot    <= '0;
          bit_out <= (op == SH_SEND) ? tx_byte[DATA_W-1] : 1'b1;
        end else if (active) begin
          slot <= slot + 4'd1;
          if (slot == 4'd7) begin
            // device acks a send and host acks a receive in the ninth bit
            bit_out <= (op == SH_SEND) ? 1'b1 : host_ack_bit;
          end else begin
            bit_out <= (op == SH_SEND) ? sreg[DATA_W-1] : 1'b1;
          end
        end
      end
      if (tick.sample && active && ack_slot && op == SH_SEND) begin
        ack_seen <= !sda_in;
      end
      if (byte_done) begin
        active <= 1'b0;
      end
    end
  end

  // msb first in both directions
  always_ff @(posedge clk) begin
    if (tick.drive && !active && op == SH_SEND) begin
      sreg <= {tx_byte[DATA_W-2:0], 1'b0};
    end else if (tick.drive && active && op == SH_SEND && !slot[3]) begin
      sreg <= {sreg[DATA_W-2:0], 1'b0};
    end else if (tick.sample && active && op == SH_RECV && !ack_slot) begin
      sreg <= {sreg[DATA_W-2:0], sda_in};
    end
  end

endmodule

//--- source/eeprom_wr.sv
`timescale 1ns/1ns
module eeprom_wr (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          start_req,
  input  eeprom_pkg::eeprom_cmd_t       cmd,
  input  eeprom_pkg::scl_tick_t         tick,
  input  logic                          byte_done,
  input  logic [eeprom_pkg::DATA_W-1:0] rx_byte,
  input  logic                          ack_seen,
  input  logic                          bit_out,
  output logic                          run,
  output eeprom_pkg::shift_op_e         op,
  output logic [eeprom_pkg::DATA_W-1:0] tx_byte,
  output logic                          host_ack_bit,
  output logic                          sda_oe,
  output logic                          done,
  output eeprom_pkg::eeprom_result_t    result
);
  import eeprom_pkg::*;

  main_state_e       state;
  logic              own_low;  // engine pulls sda for start/stop
  logic              use_sh;   // shifter owns the line
  logic              scl_hi;
  logic [DATA_W-1:0] ctrl_w;
  logic [DATA_W-1:0] ctrl_r;

  // block select from the upper address bits
  assign ctrl_w = {DEV_CODE, cmd.addr[ADDR_W-1:DATA_W], 1'b0};
  assign ctrl_r = {DEV_CODE, cmd.addr[ADDR_W-1:DATA_W], 1'b1};
  assign sda_oe = use_sh ? ~bit_out : own_low;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state        <= IDLE;
      run          <= 1'b0;
      op           <= SH_IDLE;
      tx_byte      <= '0;
      host_ack_bit <= 1'b0;
      own_low      <= 1'b0;
      use_sh       <= 1'b0;
      done         <= 1'b0;
      result       <= '0;
    end else begin
      done <= 1'b0;
      if (tick.drive && op != SH_IDLE) begin
        use_sh <= 1'b1;  // same edge the shifter puts out its first bit
      end
      if (byte_done && op == SH_SEND && !ack_seen) begin
        // no acknowledge from the device
        state      <= STOP;
        op         <= SH_IDLE;
        result.err <= 1'b1;
      end else begin
        case (state)
          IDLE: begin
            if (start_req) begin
              state        <= WRITE_START;
              run          <= 1'b1;
              result.err   <= 1'b0;
              host_ack_bit <= 1'b0;
            end
          end
          WRITE_START: begin
            if (tick.sample) begin
              own_low <= 1'b1;  // sda falls while scl high
              op      <= SH_SEND;
              tx_byte <= ctrl_w;
              state   <= CTRL_WRITE;
            end
          end
          CTRL_WRITE: begin
            if (byte_done) begin
              tx_byte <= cmd.addr[DATA_W-1:0];
              state   <= ADDR_WRITE;
            end
          end
          ADDR_WRITE: begin
            if (byte_done && cmd.is_read) begin
              op    <= SH_IDLE;
              state <= READ_START;
            end else if (byte_done) begin
              tx_byte <= cmd.wdata;
              state   <= DATA_WRITE;
            end
          end
          DATA_WRITE: begin
            if (byte_done) begin
              op    <= SH_IDLE;
              state <= STOP;
            end
          end
          READ_START: begin
            if (tick.drive) begin
              use_sh  <= 1'b0;
              own_low <= 1'b0;  // release before scl rises
            end else if (tick.sample) begin
              own_low <= 1'b1;  // repeated start
              op      <= SH_SEND;
              tx_byte <= ctrl_r;
              state   <= CTRL_READ;
            end
          end
          CTRL_READ: begin
            if (byte_done) begin
              op           <= SH_RECV;
              host_ack_bit <= 1'b1;  // no-ack on the only byte
              state        <= DATA_READ;
            end
          end
          DATA_READ: begin
            if (byte_done) begin
              result.rdata <= rx_byte;
              op           <= SH_IDLE;
              state        <= STOP;
            end
          end
          STOP: begin
            if (tick.drive) begin
              use_sh  <= 1'b0;
              own_low <= 1'b1;
            end else if (tick.sample) begin
              own_low <= 1'b0;  // sda rises while scl high
              run     <= 1'b0;
              state   <= ACKN;
            end
          end
          ACKN: begin
            done  <= 1'b1;
            state <= IDLE;
          end
          default: state <= IDLE;
        endcase
      end
    end
  end

  // scl level as seen through the ticks
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      scl_hi <= 1'b1;
    end else if (tick.rise) begin
      scl_hi <= 1'b1;
    end else if (tick.fall) begin
      scl_hi <= 1'b0;
    end
  end

  a_sda_stable: assert property (@(posedge clk) disable iff (!rst_n)
    (scl_hi && $past(scl_hi) && sda_oe != $past(sda_oe)) |->
      $past(state) inside {WRITE_START, READ_START, STOP})
    else $error("sda changed with scl high outside start or stop");

endmodule

//--- source/eeprom_ctrl_top.sv
`timescale 1ns/1ns
module eeprom_ctrl_top (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          wr,
  input  logic                          rd,
  input  logic [eeprom_pkg::ADDR_W-1:0] addr,
  input  logic [eeprom_pkg::DATA_W-1:0] wdata,
  input  logic                          sda_in,
  output logic [eeprom_pkg::DATA_W-1:0] rdata,
  output logic                          ack,
  output logic                          err,
  output logic                          busy,
  output logic                          scl,
  output logic                          sda_oe
);
  import eeprom_pkg::*;

  eeprom_cmd_t       cmd;
  eeprom_result_t    result;
  scl_tick_t         tick;
  shift_op_e         op;
  logic              start_req;
  logic              done;
  logic              run;
  logic [DATA_W-1:0] tx_byte;
  logic [DATA_W-1:0] rx_byte;
  logic              host_ack_bit;
  logic              bit_out;
  logic              byte_done;
  logic              ack_seen;

  eeprom_cmd_regs u_cmd_regs (
    .clk       (clk),
    .rst_n     (rst_n),
    .wr        (wr),
    .rd        (rd),
    .addr      (addr),
    .wdata     (wdata),
    .done      (done),
    .result    (result),
    .cmd       (cmd),
    .start_req (start_req),
    .busy      (busy),
    .ack       (ack),
    .rdata     (rdata),
    .err       (err)
  );

  eeprom_wr u_wr (
    .clk          (clk),
    .rst_n        (rst_n),
    .start_req    (start_req),
    .cmd          (cmd),
    .tick         (tick),
    .byte_done    (byte_done),
    .rx_byte      (rx_byte),
    .ack_seen     (ack_seen),
    .bit_out      (bit_out),
    .run          (run),
    .op           (op),
    .tx_byte      (tx_byte),
    .host_ack_bit (host_ack_bit),
    .sda_oe       (sda_oe),
    .done         (done),
    .result       (result)
  );

  eeprom_scl_timer u_scl_timer (
    .clk   (clk),
    .rst_n (rst_n),
    .run   (run),
    .tick  (tick),
    .scl   (scl)
  );

  eeprom_byte_shifter u_shifter (
    .clk          (clk),
    .rst_n        (rst_n),
    .tick         (tick),
    .op           (op),
    .tx_byte      (tx_byte),
    .host_ack_bit (host_ack_bit),
    .sda_in       (sda_in),
    .bit_out      (bit_out),
    .byte_done    (byte_done),
    .rx_byte      (rx_byte),
    .ack_seen     (ack_seen)
  );

endmodule

//--- dv/eeprom_bus_model.sv
`timescale 1ns/1ns
module eeprom_bus_model (
  input  logic clk,
  input  logic rst_n,
  input  logic scl,
  input  logic sda,
  output logic pull,
  output logic refused,
  output logic in_txn,
  output int   bus_errs
);
  import eeprom_pkg::*;

  logic [DATA_W-1:0] mem [0:2**ADDR_W-1];
  logic              scl_q;
  logic              sda_q;
  logic              got_rise;  // first fall after a start is not a bit
  logic              samp;
  logic              sending;
  logic              send_next;
  logic              ignore;
  logic              rep;
  logic [3:0]        bitcnt;
  logic [7:0]        shreg;
  logic [7:0]        tx;
  logic [7:0]        addr_lo;
  logic [2:0]        blk;
  int                byte_idx;

  initial begin
    for (int i = 0; i < 2**ADDR_W; i++) begin
      mem[i] = 8'hff;
    end
  end

  always @(posedge clk or negedge rst_n) begin
    logic [7:0]  nb;
    logic [31:0] roll;
    if (!rst_n) begin
      scl_q     <= 1'b1;
      sda_q     <= 1'b1;
      pull      <= 1'b0;
      refused   <= 1'b0;
      in_txn    <= 1'b0;
      got_rise  <= 1'b0;
      sending   <= 1'b0;
      send_next <= 1'b0;
      ignore    <= 1'b0;
      rep       <= 1'b0;
      bitcnt    <= '0;
      byte_idx  <= 0;
      addr_lo   <= '0;
      blk       <= '0;
      bus_errs  <= 0;
    end else begin
      scl_q <= scl;
      sda_q <= sda;
      if (scl != scl_q && sda != sda_q) begin
        $display("bus model: sda changed on the same cycle as scl");
        bus_errs <= bus_errs + 1;
      end
      if (scl && scl_q && sda_q && !sda) begin
        // mid transaction only a repeated start after the address byte is legal
        if (in_txn && !(byte_idx == 2 && bitcnt == 4'd0)) begin
          $display("bus model: start inside a transaction that had no stop");
          bus_errs <= bus_errs + 1;
        end
        if (!in_txn) refused <= 1'b0;
        rep       <= in_txn;
        in_txn    <= 1'b1;
        bitcnt    <= '0;
        byte_idx  <= 0;
        got_rise  <= 1'b0;
        sending   <= 1'b0;
        send_next <= 1'b0;
        ignore    <= 1'b0;
        pull      <= 1'b0;
      end else if (scl && scl_q && !sda_q && sda) begin
        if (!in_txn || bitcnt != 4'd0) begin
          $display("bus model: stop outside a transaction or inside a byte");
          bus_errs <= bus_errs + 1;
        end
        in_txn  <= 1'b0;
        sending <= 1'b0;
        pull    <= 1'b0;
      end else if (scl && !scl_q) begin
        got_rise <= 1'b1;
        samp     <= sda;
      end else if (!scl && scl_q && got_rise && in_txn && !ignore) begin
        if (bitcnt < 4'd8) begin
          nb = {shreg[6:0], samp};
          shreg  <= nb;
          bitcnt <= bitcnt + 4'd1;
          if (bitcnt == 4'd7) begin
            pull <= 1'b0;  // master acks our data byte
            if (!sending) begin
              case (byte_idx)
                0: begin
                  roll = $urandom;
                  if (nb[7:4] != DEV_CODE) begin
                    $display("bus model: control byte with a wrong device code");
                    bus_errs <= bus_errs + 1;
                  end else if (!rep && roll[3:0] == 4'd0) begin
                    refused <= 1'b1;  // no ack until the stop
                    ignore  <= 1'b1;
                    bitcnt  <= '0;
                  end else begin
                    blk  <= nb[3:1];
                    pull <= 1'b1;
                    if (nb[0]) begin
                      send_next <= 1'b1;
                      tx        <= mem[{nb[3:1], addr_lo}];
                    end
                  end
                end
                1: begin
                  addr_lo <= nb;
                  pull    <= 1'b1;
                end
                default: begin
                  mem[{blk, addr_lo}] <= nb;
                  pull                <= 1'b1;
                end
              endcase
            end
          end else if (sending) begin
            pull <= !tx[3'd6 - bitcnt[2:0]];
          end
        end else begin
          bitcnt   <= '0;
          byte_idx <= byte_idx + 1;
          pull     <= 1'b0;
          if (send_next) begin
            sending   <= 1'b1;
            send_next <= 1'b0;
            pull      <= !tx[7];
          end else begin
            sending <= 1'b0;
          end
        end
      end
    end
  end

endmodule

//--- dv/eeprom_checker.sv
`timescale 1ns/1ns
module eeprom_checker (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          wr,
  input  logic                          rd,
  input  logic [eeprom_pkg::ADDR_W-1:0] addr,
  input  logic [eeprom_pkg::DATA_W-1:0] wdata,
  input  logic [eeprom_pkg::DATA_W-1:0] rdata,
  input  logic                          ack,
  input  logic                          err,
  input  logic                          busy,
  input  logic                          scl,
  input  logic                          sda_oe,
  input  logic                          refused,
  input  logic                          in_txn,
  output int                            errors
);
  import eeprom_pkg::*;

  logic [DATA_W-1:0] img [0:2**ADDR_W-1];  // expected memory
  logic              after_rst;
  logic              outstanding;
  logic              p_read;
  logic [ADDR_W-1:0] p_addr;
  logic [DATA_W-1:0] p_wdata;

  initial begin
    for (int i = 0; i < 2**ADDR_W; i++) begin
      img[i] = 8'hff;
    end
  end

  always @(posedge clk) begin
    if (!rst_n) begin
      errors      = 0;
      after_rst   = 1'b1;
      outstanding = 1'b0;
    end else begin
      if (after_rst) begin
        after_rst = 1'b0;
        if (busy || !scl || sda_oe) begin
          $display("ERR reset state busy=%0h scl=%0h sda_oe=%0h exp 0 1 0", busy, scl, sda_oe);
          errors++;
        end
      end
      if (wr || rd) begin
        if (outstanding || busy) begin
          $display("checker: strobe issued while a command was still running");
          errors++;
        end
        outstanding = 1'b1;
        p_read      = rd;
        p_addr      = addr;
        p_wdata     = wdata;
      end else if (outstanding && ack) begin
        outstanding = 1'b0;
        if (in_txn) begin
          $display("checker: ack came before the bus saw a stop");
          errors++;
        end
        if (err != refused) begin
          $display("ERR err addr=%03h got=%0h exp=%0h", p_addr, err, refused);
          errors++;
        end
        if (!refused && p_read && rdata !== img[p_addr]) begin
          $display("ERR rdata addr=%03h got=%02h exp=%02h", p_addr, rdata, img[p_addr]);
          errors++;
        end else if (!refused && !p_read) begin
          img[p_addr] = p_wdata;
        end
      end else if (outstanding && !busy) begin
        $display("ERR busy got=0 exp=1");
        errors++;
      end else if (!outstanding && ack) begin
        $display("checker: ack without a pending command");
        errors++;
      end
    end
  end

endmodule

//--- dv/eeprom_tb.sv
`timescale 1ns/1ns
module eeprom_tb;
  import eeprom_pkg::*;

  localparam int N_TXN    = 200;
  localparam int TXN_CLKS = 400;  // longest read is well under this
  localparam int LIMIT    = N_TXN * TXN_CLKS + 200;

  logic              clk;
  logic              rst_n;
  logic              wr;
  logic              rd;
  logic [ADDR_W-1:0] addr;
  logic [DATA_W-1:0] wdata;
  logic              sda_in;
  logic [DATA_W-1:0] rdata;
  logic              ack;
  logic              err;
  logic              busy;
  logic              scl;
  logic              sda_oe;
  logic              model_pull;
  logic              refused;
  logic              in_txn;
  int                chk_errs;
  int                bus_errs;
  int                cycles = 0;
  logic [31:0]       r;
  logic [31:0]       a;
  logic [31:0]       w;

  assign sda_in = !(sda_oe || model_pull);  // wired-and line

  eeprom_ctrl_top dut0 (
    .clk    (clk),
    .rst_n  (rst_n),
    .wr     (wr),
    .rd     (rd),
    .addr   (addr),
    .wdata  (wdata),
    .sda_in (sda_in),
    .rdata  (rdata),
    .ack    (ack),
    .err    (err),
    .busy   (busy),
    .scl    (scl),
    .sda_oe (sda_oe)
  );

  eeprom_bus_model u_model (
    .clk      (clk),
    .rst_n    (rst_n),
    .scl      (scl),
    .sda      (sda_in),
    .pull     (model_pull),
    .refused  (refused),
    .in_txn   (in_txn),
    .bus_errs (bus_errs)
  );

  eeprom_checker u_checker (
    .clk     (clk),
    .rst_n   (rst_n),
    .wr      (wr),
    .rd      (rd),
    .addr    (addr),
    .wdata   (wdata),
    .rdata   (rdata),
    .ack     (ack),
    .err     (err),
    .busy    (busy),
    .scl     (scl),
    .sda_oe  (sda_oe),
    .refused (refused),
    .in_txn  (in_txn),
    .errors  (chk_errs)
  );

  task automatic finish_run(input logic timed_out);
    int total;
    total = chk_errs + bus_errs + (timed_out ? 1 : 0);
    $display("errors: checker %0d, bus %0d, timeout %0d", chk_errs, bus_errs,
             timed_out ? 1 : 0);
    if (total == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  endtask

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles == LIMIT) begin
      $display("timeout: a command got no ack within %0d cycles", LIMIT);
      finish_run(1'b1);
    end
  end

  initial begin
    wr    = 1'b0;
    rd    = 1'b0;
    addr  = '0;
    wdata = '0;
    rst_n = 1'b0;
    r     = $urandom(32'hae5e);
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    repeat (4) @(posedge clk);
    for (int i = 0; i < N_TXN; i++) begin
      r = $urandom;
      a = $urandom;
      w = $urandom;
      wr <= !r[0];
      rd <= r[0];
      // small window per block so reads mostly hit written bytes
      addr  <= (r[3:1] == 3'd0) ? a[10:0] : {a[10:8], 6'b0, a[1:0]};
      wdata <= w[7:0];
      @(posedge clk);
      wr <= 1'b0;
      rd <= 1'b0;
      do @(posedge clk); while (!ack);
    end
    repeat (10) @(posedge clk);
    finish_run(1'b0);
  end

endmodule

//--- sim.f
source/eeprom_pkg.sv
source/eeprom_cmd_regs.sv
source/eeprom_scl_timer.sv
source/eeprom_byte_shifter.sv
source/eeprom_wr.sv
source/eeprom_ctrl_top.sv
dv/eeprom_bus_model.sv
dv/eeprom_checker.sv
dv/eeprom_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module eeprom_tb -f sim.f -o eeprom_sim > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "build failed"
  exit 1
fi

./obj_dir/eeprom_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "TEST OK" sim.log; then
  exit 0
fi
exit 1
